// File: logic/cpu_bus_pkg.sv
// Memory bus types for the 6502 core: address and data bytes, request and response
package cpu_bus_pkg;

   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // Strobes hold with addr and wdata until ready
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  rd;
      logic  wr;
   } mem_req_t;

   typedef struct packed {
      data_t rdata;   // Valid with ready
      logic  ready;
   } mem_rsp_t;

   localparam addr_t VECTOR_RESET = 16'hFFFC;

endpackage

// File: logic/cpu_isa_pkg.sv
// Instruction-level types for the 6502 subset: operations, modes, ALU controls and flags
package cpu_isa_pkg;

   typedef enum logic [4:0] {
      OP_NOP,
      OP_LDA, OP_LDX, OP_LDY,
      OP_STA, OP_STX, OP_STY,
      OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_SBC, OP_CMP,
      OP_TAX, OP_TAY, OP_TXA, OP_TYA, OP_TSX, OP_TXS,
      OP_INX, OP_INY, OP_DEX, OP_DEY,
      OP_CLC, OP_SEC,
      OP_BRANCH
   } cpu_op_e;

   typedef enum logic [2:0] {
      MODE_SINGLE,
      MODE_ACC,
      MODE_IMM,
      MODE_ZP,
      MODE_ABS
   } addr_mode_e;

   typedef enum logic [2:0] {
      ALU_PASS, ALU_OR, ALU_AND, ALU_EOR, ALU_ADC, ALU_CMP, ALU_INC, ALU_DEC
   } alu_op_e;

   typedef enum logic [2:0] {
      SEL_NONE, SEL_A, SEL_X, SEL_Y, SEL_SP
   } reg_sel_e;

   typedef logic [2:0] branch_cond_t;   // aaa field of a branch opcode

   typedef struct packed {
      cpu_op_e      op;
      addr_mode_e   mode;
      alu_op_e      alu_op;
      reg_sel_e     src;         // ALU operand A, NONE takes the memory byte
      reg_sel_e     dst;
      reg_sel_e     store_src;
      logic         invert;      // SBC
      logic         is_load;
      logic         is_store;
      branch_cond_t branch_cond;
   } decoded_inst_t;

   typedef struct packed {
      logic n;
      logic v;
      logic z;
      logic c;
   } flags_t;

endpackage

// File: logic/m6502_decoder.sv
// Opcode decoder splitting aaabbbcc into operation, addressing mode and datapath controls
`timescale 1ns/1ps

module m6502_decoder (
   input  cpu_bus_pkg::data_t         opcode,
   output cpu_isa_pkg::decoded_inst_t inst
);
   import cpu_isa_pkg::*;

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;
   addr_mode_e mem_mode;

   assign aaa = opcode[7:5];
   assign bbb = opcode[4:2];
   assign cc  = opcode[1:0];

   // Register-only instruction, accumulator mode when A is involved
   function automatic decoded_inst_t single(cpu_op_e op, reg_sel_e src, reg_sel_e dst,
                                            alu_op_e alu_op);
      decoded_inst_t d;
      d        = '0;
      d.op     = op;
      d.src    = src;
      d.dst    = dst;
      d.alu_op = alu_op;
      d.mode   = (src == SEL_A || dst == SEL_A) ? MODE_ACC : MODE_SINGLE;
      return d;
   endfunction

   always_comb
   begin
      case (bbb)
         3'b001:  mem_mode = MODE_ZP;
         3'b011:  mem_mode = MODE_ABS;
         default: mem_mode = MODE_IMM;   // bbb 000 or 010 depending on cc
      endcase
   end

   always_comb
   begin
      inst             = '0;   // NOP
      inst.branch_cond = aaa;
      case (cc)
         2'b01:
            if (bbb inside {3'b001, 3'b010, 3'b011} && !(aaa == 3'b100 && bbb == 3'b010))
            begin
               inst.mode    = mem_mode;
               inst.src     = SEL_A;
               inst.dst     = SEL_A;
               inst.is_load = 1'b1;
               inst.invert  = aaa == 3'b111;
               case (aaa)
                  3'b000:  inst.op = OP_ORA;
                  3'b001:  inst.op = OP_AND;
                  3'b010:  inst.op = OP_EOR;
                  3'b011:  inst.op = OP_ADC;
                  3'b100:  inst.op = OP_STA;
                  3'b101:  inst.op = OP_LDA;
                  3'b110:  inst.op = OP_CMP;
                  default: inst.op = OP_SBC;
               endcase
               case (aaa)
                  3'b000:         inst.alu_op = ALU_OR;
                  3'b001:         inst.alu_op = ALU_AND;
                  3'b010:         inst.alu_op = ALU_EOR;
                  3'b011, 3'b111: inst.alu_op = ALU_ADC;
                  3'b110:         inst.alu_op = ALU_CMP;
                  default:        inst.alu_op = ALU_PASS;
               endcase
               if (aaa == 3'b100)
               begin
                  inst.src       = SEL_NONE;
                  inst.dst       = SEL_NONE;
                  inst.store_src = SEL_A;
                  inst.is_load   = 1'b0;
                  inst.is_store  = 1'b1;
               end
               if (aaa == 3'b101)
                  inst.src = SEL_NONE;   // LDA passes the memory byte
               if (aaa == 3'b110)
                  inst.dst = SEL_NONE;
            end
         2'b00, 2'b10:
            if (cc == 2'b00 && bbb == 3'b100)
            begin
               inst.op   = OP_BRANCH;
               inst.mode = MODE_IMM;
            end
            else
            begin
               case ({aaa, bbb})
                  6'b100_001, 6'b100_011:
                  begin
                     inst.op        = cc[1] ? OP_STX : OP_STY;
                     inst.mode      = mem_mode;
                     inst.store_src = cc[1] ? SEL_X : SEL_Y;
                     inst.is_store  = 1'b1;
                  end
                  6'b101_000, 6'b101_001, 6'b101_011:
                  begin
                     inst.op      = cc[1] ? OP_LDX : OP_LDY;
                     inst.mode    = mem_mode;
                     inst.dst     = cc[1] ? SEL_X : SEL_Y;
                     inst.is_load = 1'b1;
                  end
                  default:
                     case ({cc[1], aaa, bbb})
                        7'b1_100_010: inst = single(OP_TXA, SEL_X, SEL_A, ALU_PASS);
                        7'b1_100_110: inst = single(OP_TXS, SEL_X, SEL_SP, ALU_PASS);
                        7'b1_101_010: inst = single(OP_TAX, SEL_A, SEL_X, ALU_PASS);
                        7'b1_101_110: inst = single(OP_TSX, SEL_SP, SEL_X, ALU_PASS);
                        7'b1_110_010: inst = single(OP_DEX, SEL_X, SEL_X, ALU_DEC);
                        7'b0_000_110: inst = single(OP_CLC, SEL_NONE, SEL_NONE, ALU_PASS);
                        7'b0_001_110: inst = single(OP_SEC, SEL_NONE, SEL_NONE, ALU_PASS);
                        7'b0_100_110: inst = single(OP_TYA, SEL_Y, SEL_A, ALU_PASS);
                        7'b0_100_010: inst = single(OP_DEY, SEL_Y, SEL_Y, ALU_DEC);
                        7'b0_101_010: inst = single(OP_TAY, SEL_A, SEL_Y, ALU_PASS);
                        7'b0_110_010: inst = single(OP_INY, SEL_Y, SEL_Y, ALU_INC);
                        7'b0_111_010: inst = single(OP_INX, SEL_X, SEL_X, ALU_INC);
                        default:      inst.op = OP_NOP;
                     endcase
               endcase
            end
         default: inst.op = OP_NOP;
      endcase
   end

endmodule

// File: logic/m6502_sequencer.sv
// Instruction-cycle FSM owning PC, opcode register, bus requests and branch decision
`timescale 1ns/1ps

module m6502_sequencer #(
   parameter cpu_bus_pkg::addr_t RESET_VECTOR = cpu_bus_pkg::VECTOR_RESET
) (
   input  logic                       clk,
   input  logic                       reset_n,
   output cpu_bus_pkg::mem_req_t      mem_req,
   input  cpu_bus_pkg::mem_rsp_t      mem_rsp,
   output cpu_bus_pkg::data_t         opcode,
   input  cpu_isa_pkg::decoded_inst_t inst,
   input  cpu_bus_pkg::data_t         regs_a,
   input  cpu_bus_pkg::data_t         regs_x,
   input  cpu_bus_pkg::data_t         regs_y,
   input  cpu_isa_pkg::flags_t        flags,
   output cpu_bus_pkg::data_t         operand,
   output logic                       reg_we,
   output logic                       flag_we,
   output logic                       carry_set,
   output logic                       carry_clear
);
   import cpu_bus_pkg::*;
   import cpu_isa_pkg::*;

   typedef enum logic [2:0] {
      S_VEC_LO, S_VEC_HI, S_FETCH, S_OPER_LO, S_OPER_HI, S_DATA, S_EXEC
   } state_e;

   state_e state;
   addr_t  pc;
   addr_t  pc_next;
   data_t  addr_lo;
   data_t  store_data;
   logic   busy;
   logic   done;
   logic   data_phase;
   logic   flag_sel;
   logic   taken;

   assign busy       = mem_req.rd | mem_req.wr;
   assign done       = busy & mem_rsp.ready;
   assign data_phase = inst.is_load | inst.is_store;

   assign reg_we      = state == S_EXEC && inst.dst != SEL_NONE;
   assign flag_we     = state == S_EXEC &&
                        ((inst.dst != SEL_NONE && inst.op != OP_TXS) || inst.op == OP_CMP);
   assign carry_set   = state == S_EXEC && inst.op == OP_SEC;
   assign carry_clear = state == S_EXEC && inst.op == OP_CLC;

   always_comb
   begin
      case (inst.store_src)
         SEL_X:   store_data = regs_x;
         SEL_Y:   store_data = regs_y;
         default: store_data = regs_a;
      endcase
      case (inst.branch_cond[2:1])
         2'b00:   flag_sel = flags.n;
         2'b01:   flag_sel = flags.v;
         2'b10:   flag_sel = flags.c;
         default: flag_sel = flags.z;
      endcase
      taken   = inst.op == OP_BRANCH && flag_sel == inst.branch_cond[0];
      pc_next = taken ? pc + {{8{operand[7]}}, operand} : pc;   // PC already at opcode+2
   end

   function automatic mem_req_t read_req(addr_t addr);
      mem_req_t req;
      req      = '0;
      req.addr = addr;
      req.rd   = 1'b1;
      return req;
   endfunction

   function automatic mem_req_t data_req(addr_t addr);
      mem_req_t req;
      req       = '0;
      req.addr  = addr;
      req.wdata = store_data;
      req.rd    = !inst.is_store;
      req.wr    = inst.is_store;
      return req;
   endfunction

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state   <= S_VEC_LO;
         mem_req <= '0;
      end
      else
      begin
         case (state)
            S_VEC_LO:
               if (!busy)
                  mem_req <= read_req(RESET_VECTOR);
               else if (done)
               begin
                  addr_lo <= mem_rsp.rdata;
                  mem_req <= read_req(RESET_VECTOR + 16'd1);
                  state   <= S_VEC_HI;
               end
            S_VEC_HI:
               if (done)
               begin
                  pc      <= {mem_rsp.rdata, addr_lo};
                  mem_req <= read_req({mem_rsp.rdata, addr_lo});
                  state   <= S_FETCH;
               end
            S_FETCH:
               if (done)
               begin
                  opcode  <= mem_rsp.rdata;
                  pc      <= pc + 16'd1;
                  mem_req <= '0;   // Decode cycle
                  state   <= S_OPER_LO;
               end
            S_OPER_LO:
               if (!busy)
               begin
                  if (inst.mode == MODE_SINGLE || inst.mode == MODE_ACC)
                     state <= S_EXEC;
                  else
                     mem_req <= read_req(pc);
               end
               else if (done)
               begin
                  addr_lo <= mem_rsp.rdata;
                  operand <= mem_rsp.rdata;   // Immediate or branch offset
                  pc      <= pc + 16'd1;
                  mem_req <= '0;
                  state   <= S_EXEC;
                  if (inst.mode == MODE_ABS)
                  begin
                     mem_req <= read_req(pc + 16'd1);
                     state   <= S_OPER_HI;
                  end
                  else if (inst.mode == MODE_ZP && data_phase)
                  begin
                     mem_req <= data_req({8'h00, mem_rsp.rdata});
                     state   <= S_DATA;
                  end
               end
            S_OPER_HI:
               if (done)
               begin
                  pc      <= pc + 16'd1;
                  mem_req <= data_req({mem_rsp.rdata, addr_lo});
                  state   <= S_DATA;
               end
            S_DATA:
               if (done)
               begin
                  if (mem_req.rd)
                     operand <= mem_rsp.rdata;
                  mem_req <= '0;
                  state   <= S_EXEC;
               end
            S_EXEC:
            begin
               pc      <= pc_next;   // Write-back happens on this edge too
               mem_req <= read_req(pc_next);
               state   <= S_FETCH;
            end
            default: state <= S_VEC_LO;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!reset_n) !(mem_req.rd && mem_req.wr))
      else $error("Read and write strobes high together");

   assert property (@(posedge clk) disable iff (!reset_n)
                    busy && !mem_rsp.ready |=> $stable(mem_req))
      else $error("Request changed while ready was low");

endmodule

// File: logic/m6502_registers.sv
// A, X, Y and SP register file written back from the ALU result
`timescale 1ns/1ps

module m6502_registers (
   input  logic                       clk,
   input  logic                       reset_n,
   input  cpu_isa_pkg::decoded_inst_t inst,
   input  logic                       we,
   input  cpu_bus_pkg::data_t         result,
   output cpu_bus_pkg::data_t         a,
   output cpu_bus_pkg::data_t         x,
   output cpu_bus_pkg::data_t         y,
   output cpu_bus_pkg::data_t         sp
);
   import cpu_isa_pkg::*;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         a  <= 8'h00;
         x  <= 8'h00;
         y  <= 8'h00;
         sp <= 8'hFF;
      end
      else if (we)
      begin
         if (inst.op == OP_TXS)
            sp <= x;   // Straight copy, flags untouched
         else
            case (inst.dst)
               SEL_A:   a <= result;
               SEL_X:   x <= result;
               SEL_Y:   y <= result;
               default: sp <= sp;
            endcase
      end
   end

endmodule

// File: logic/m6502_alu.sv
// Byte ALU with operand select, SBC inversion and the registered N V Z C flags
`timescale 1ns/1ps

module m6502_alu (
   input  logic                       clk,
   input  logic                       reset_n,
   input  cpu_isa_pkg::decoded_inst_t inst,
   input  cpu_bus_pkg::data_t         a,
   input  cpu_bus_pkg::data_t         x,
   input  cpu_bus_pkg::data_t         y,
   input  cpu_bus_pkg::data_t         sp,
   input  cpu_bus_pkg::data_t         operand,
   input  logic                       flag_we,
   input  logic                       carry_set,
   input  logic                       carry_clear,
   output cpu_bus_pkg::data_t         result,
   output cpu_isa_pkg::flags_t        flags
);
   import cpu_bus_pkg::*;
   import cpu_isa_pkg::*;

   data_t      in_a;
   data_t      in_b;
   logic [8:0] sum;
   logic       ovf;

   always_comb
   begin
      case (inst.src)
         SEL_A:   in_a = a;
         SEL_X:   in_a = x;
         SEL_Y:   in_a = y;
         SEL_SP:  in_a = sp;
         default: in_a = operand;   // Loads
      endcase
      in_b = inst.invert ? ~operand : operand;
      // Compare is A minus M with carry forced in
      if (inst.alu_op == ALU_CMP)
         sum = {1'b0, in_a} + {1'b0, ~operand} + 9'd1;
      else
         sum = {1'b0, in_a} + {1'b0, in_b} + {8'd0, flags.c};
      ovf = (in_a[7] == in_b[7]) && (sum[7] != in_a[7]);
      case (inst.alu_op)
         ALU_OR:           result = in_a | in_b;
         ALU_AND:          result = in_a & in_b;
         ALU_EOR:          result = in_a ^ in_b;
         ALU_ADC, ALU_CMP: result = sum[7:0];
         ALU_INC:          result = in_a + 8'd1;
         ALU_DEC:          result = in_a - 8'd1;
         default:          result = in_a;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         flags <= '0;
      else
      begin
         if (flag_we)
         begin
            flags.n <= result[7];
            flags.z <= result == 8'h00;
            if (inst.alu_op == ALU_ADC)
            begin
               flags.c <= sum[8];
               flags.v <= ovf;
            end
            else if (inst.alu_op == ALU_CMP)
               flags.c <= sum[8];   // A >= M
         end
         if (carry_set)
            flags.c <= 1'b1;
         else if (carry_clear)
            flags.c <= 1'b0;
      end
   end

endmodule

// File: logic/m6502_core.sv
// 6502 subset core joining decoder, sequencer, registers and ALU on a byte-wide bus
`timescale 1ns/1ps

module m6502_core #(
   parameter cpu_bus_pkg::addr_t RESET_VECTOR = cpu_bus_pkg::VECTOR_RESET
) (
   input  logic                  clk,
   input  logic                  reset_n,
   output cpu_bus_pkg::mem_req_t mem_req,
   input  cpu_bus_pkg::mem_rsp_t mem_rsp
);
   import cpu_bus_pkg::*;
   import cpu_isa_pkg::*;

   data_t         opcode;
   data_t         operand;
   data_t         result;
   data_t         reg_a;
   data_t         reg_x;
   data_t         reg_y;
   data_t         reg_sp;
   decoded_inst_t inst;
   flags_t        flags;
   logic          reg_we;
   logic          flag_we;
   logic          carry_set;
   logic          carry_clear;

   m6502_decoder u_decoder (
      .opcode (opcode),
      .inst   (inst)
   );

   m6502_sequencer #(
      .RESET_VECTOR (RESET_VECTOR)
   ) u_sequencer (
      .clk         (clk),
      .reset_n     (reset_n),
      .mem_req     (mem_req),
      .mem_rsp     (mem_rsp),
      .opcode      (opcode),
      .inst        (inst),
      .regs_a      (reg_a),
      .regs_x      (reg_x),
      .regs_y      (reg_y),
      .flags       (flags),
      .operand     (operand),
      .reg_we      (reg_we),
      .flag_we     (flag_we),
      .carry_set   (carry_set),
      .carry_clear (carry_clear)
   );

   m6502_registers u_registers (
      .clk     (clk),
      .reset_n (reset_n),
      .inst    (inst),
      .we      (reg_we),
      .result  (result),
      .a       (reg_a),
      .x       (reg_x),
      .y       (reg_y),
      .sp      (reg_sp)
   );

   m6502_alu u_alu (
      .clk         (clk),
      .reset_n     (reset_n),
      .inst        (inst),
      .a           (reg_a),
      .x           (reg_x),
      .y           (reg_y),
      .sp          (reg_sp),
      .operand     (operand),
      .flag_we     (flag_we),
      .carry_set   (carry_set),
      .carry_clear (carry_clear),
      .result      (result),
      .flags       (flags)
   );

endmodule

// File: verification/m6502_memory_model.sv
// Testbench memory of 64 KiB with random wait states, a write log and a request stability check
`timescale 1ns/1ps

module m6502_memory_model (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  wait_en,
   input  cpu_bus_pkg::mem_req_t mem_req,
   output cpu_bus_pkg::mem_rsp_t mem_rsp
);
   import cpu_bus_pkg::*;

   data_t    mem [0:65535];
   addr_t    wr_addr [0:255];
   data_t    wr_data [0:255];
   addr_t    rd_addr [0:7];
   int       wr_count;
   int       rd_count;
   int       stall_errors;
   int       seed;
   int       wait_left;
   logic     stalled;
   logic     busy;
   mem_req_t held;

   initial
   begin
      seed         = 75;
      wr_count     = 0;
      rd_count     = 0;
      stall_errors = 0;
      wait_left    = 0;
      stalled      = 1'b0;
   end

   assign busy    = mem_req.rd | mem_req.wr;
   assign mem_rsp = {mem[mem_req.addr], busy && wait_left == 0};

   task automatic clear_log();
      wr_count = 0;
      rd_count = 0;
   endtask

   always @(posedge clk)
   begin
      if (!reset_n)
      begin
         stalled   = 1'b0;
         wait_left = 0;
      end
      else
      begin
         if (stalled && mem_req !== held)
            stall_errors++;
         stalled = 1'b0;
         if (busy && mem_rsp.ready)
         begin
            if (mem_req.wr)
            begin
               mem[mem_req.addr] = mem_req.wdata;
               if (wr_count < 256)
               begin
                  wr_addr[wr_count[7:0]] = mem_req.addr;
                  wr_data[wr_count[7:0]] = mem_req.wdata;
               end
               wr_count++;
            end
            else if (rd_count < 8)
            begin
               rd_addr[rd_count[2:0]] = mem_req.addr;
               rd_count++;
            end
            #1 wait_left = wait_en ? {$random(seed)} % 3 : 0;   // 0 to 2 stall cycles
         end
         else if (busy)
         begin
            held    = mem_req;
            stalled = 1'b1;
            #1 wait_left = wait_left - 1;
         end
      end
   end

endmodule

// File: verification/m6502_tb.sv
// Directed testbench for the 6502 subset core with a program-image memory model
`timescale 1ns/1ps

module m6502_tb;
   import cpu_bus_pkg::*;

   logic     clk;
   logic     reset_n;
   logic     wait_en;
   mem_req_t req0;
   mem_req_t req1;
   mem_rsp_t rsp0;
   mem_rsp_t rsp1;
   addr_t    load_pc;
   addr_t    exp_addr [0:255];
   data_t    exp_data [0:255];
   addr_t    ref_addr [0:255];
   data_t    ref_data [0:255];
   int       exp_count;
   int       value_errors;
   int       other_errors;
   data_t    ma;
   data_t    mx;
   data_t    my;
   logic     fn;
   logic     fv;
   logic     fz;
   logic     fc;

   m6502_core dut0 (.clk(clk), .reset_n(reset_n), .mem_req(req0), .mem_rsp(rsp0));
   m6502_memory_model mem0 (.clk(clk), .reset_n(reset_n), .wait_en(wait_en),
                            .mem_req(req0), .mem_rsp(rsp0));

   // Second core with a moved vector
   m6502_core #(.RESET_VECTOR(16'hFFF0)) dut1 (.clk(clk), .reset_n(reset_n),
                                               .mem_req(req1), .mem_rsp(rsp1));
   m6502_memory_model mem1 (.clk(clk), .reset_n(reset_n), .wait_en(wait_en),
                            .mem_req(req1), .mem_rsp(rsp1));

   always #10 clk = ~clk;

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp)
      begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp)
      begin
         $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic emit(input data_t b);
      mem0.mem[load_pc] = b;
      load_pc++;
   endtask

   task automatic expect_write(input addr_t addr, input data_t data);
      exp_addr[exp_count[7:0]] = addr;
      exp_data[exp_count[7:0]] = data;
      exp_count++;
   endtask

   task automatic set_nz(input data_t v);
      fn = v[7];
      fz = v == 8'h00;
   endtask

   // Hold reset, fill memory and point the vector at the program
   task automatic start_program(input addr_t entry);
      int i;
      @(posedge clk);
      #1 reset_n = 1'b0;
      for (i = 0; i < 65536; i++)
         mem0.mem[i[15:0]] = i[7:0] ^ i[15:8] ^ 8'h5A;
      mem0.mem[16'hFFFC] = entry[7:0];
      mem0.mem[16'hFFFD] = entry[15:8];
      mem0.clear_log();
      load_pc   = entry;
      exp_count = 0;
      {ma, mx, my} = '0;
      {fn, fv, fz, fc} = '0;
   endtask

   task automatic load_imm(input logic [1:0] cc, input data_t v);
      emit({3'b101, cc == 2'b01 ? 3'b010 : 3'b000, cc});
      emit(v);
      if (cc == 2'b01) ma = v;
      else if (cc == 2'b10) mx = v;
      else my = v;
      set_nz(v);
   endtask

   task automatic load_mem(input logic [1:0] cc, input addr_t addr, input data_t m);
      emit({3'b101, addr[15:8] == 8'h00 ? 3'b001 : 3'b011, cc});
      emit(addr[7:0]);
      if (addr[15:8] != 8'h00) emit(addr[15:8]);
      mem0.mem[addr] = m;
      if (cc == 2'b01) ma = m;
      else if (cc == 2'b10) mx = m;
      else my = m;
      set_nz(m);
   endtask

   // cc 01 stores A, 10 stores X, 00 stores Y
   task automatic store(input logic [1:0] cc, input addr_t addr);
      emit({3'b100, addr[15:8] == 8'h00 ? 3'b001 : 3'b011, cc});
      emit(addr[7:0]);
      if (addr[15:8] != 8'h00) emit(addr[15:8]);
      expect_write(addr, cc == 2'b01 ? ma : (cc == 2'b10 ? mx : my));
   endtask

   // 6502 rules for the aaa group of cc=01
   task automatic model_alu(input logic [2:0] aaa, input data_t m);
      logic [8:0] s;
      data_t      b;
      int         signed_sum;
      b = (aaa == 3'b111) ? ~m : m;
      s = {1'b0, ma} + {1'b0, b} + {8'd0, fc};
      signed_sum = int'($signed(ma)) + int'($signed(b)) + int'(fc);
      case (aaa)
         3'b000: ma = ma | m;
         3'b001: ma = ma & m;
         3'b010: ma = ma ^ m;
         3'b110:
         begin
            fc = ma >= m;
            s  = {1'b0, ma - m};
         end
         default:
         begin
            fv = signed_sum > 127 || signed_sum < -128;   // Out of signed byte range
            fc = s[8];
            ma = s[7:0];
         end
      endcase
      set_nz(aaa == 3'b110 ? s[7:0] : ma);
   endtask

   task automatic alu_imm(input logic [2:0] aaa, input data_t v);
      emit({aaa, 3'b010, 2'b01});
      emit(v);
      model_alu(aaa, v);
   endtask

   task automatic alu_mem(input logic [2:0] aaa, input addr_t addr, input data_t m);
      emit({aaa, addr[15:8] == 8'h00 ? 3'b001 : 3'b011, 2'b01});
      emit(addr[7:0]);
      if (addr[15:8] != 8'h00) emit(addr[15:8]);
      mem0.mem[addr] = m;
      model_alu(aaa, m);
   endtask

   task automatic set_carry(input logic c);
      emit(c ? 8'h38 : 8'h18);
      fc = c;
   endtask

   // Branch over an STX marker, which is written only when not taken
   task automatic branch_skip(input data_t opc, input data_t zp);
      logic f;
      case (opc[7:6])
         2'b00:   f = fn;
         2'b01:   f = fv;
         2'b10:   f = fc;
         default: f = fz;
      endcase
      emit(opc);
      emit(8'h02);
      emit(8'h86);
      emit(zp);
      if (f != opc[5])
         expect_write({8'h00, zp}, mx);
   endtask

   task automatic run_and_check(input string name);
      int i;
      emit(8'h18);   // Park in a CLC, BCC self loop
      emit(8'h90);
      emit(8'hFE);
      repeat (5) @(posedge clk);
      #1 reset_n = 1'b1;
      i = 0;
      while (mem0.wr_count < exp_count && i < 5000)
      begin
         @(negedge clk);
         i++;
      end
      if (mem0.wr_count < exp_count)
      begin
         $display("%s timed out waiting for %0d writes, saw %0d", name, exp_count,
                  mem0.wr_count);
         $display(">>> FAIL");
         $finish;
      end
      repeat (40) @(negedge clk);
      if (mem0.wr_count != exp_count)
      begin
         $display("%s wrote %0d bytes instead of %0d", name, mem0.wr_count, exp_count);
         other_errors++;
      end
      for (i = 0; i < exp_count; i++)
      begin
         check_addr({name, " write addr"}, mem0.wr_addr[i[7:0]], exp_addr[i[7:0]]);
         check_data({name, " write data"}, mem0.wr_data[i[7:0]], exp_data[i[7:0]]);
      end
   endtask

   task automatic test_reset_vector();
      start_program(16'h0300);
      mem1.mem[16'hFFF0] = 8'h00;
      mem1.mem[16'hFFF1] = 8'h04;
      mem1.mem[16'h0400] = 8'h18;
      mem1.mem[16'h0401] = 8'h90;
      mem1.mem[16'h0402] = 8'hFE;
      mem1.clear_log();
      load_imm(2'b01, 8'h5A);
      store(2'b01, 16'h0010);
      run_and_check("reset");
      check_addr("read 0", mem0.rd_addr[0], 16'hFFFC);
      check_addr("read 1", mem0.rd_addr[1], 16'hFFFD);
      check_addr("read 2", mem0.rd_addr[2], 16'h0300);
      check_addr("dut1 read 0", mem1.rd_addr[0], 16'hFFF0);
      check_addr("dut1 read 1", mem1.rd_addr[1], 16'hFFF1);
      check_addr("dut1 read 2", mem1.rd_addr[2], 16'h0400);
   endtask

   task automatic test_loads_stores();
      start_program(16'h0200);
      load_imm(2'b01, 8'h11);
      store(2'b01, 16'h0020);
      load_mem(2'b10, 16'h0030, 8'h22);
      store(2'b10, 16'h0421);
      load_mem(2'b00, 16'h0500, 8'h33);
      store(2'b00, 16'h0022);
      load_mem(2'b01, 16'h0031, 8'h44);
      store(2'b01, 16'h0423);
      load_imm(2'b10, 8'h55);
      store(2'b10, 16'h0024);
      load_imm(2'b00, 8'h66);
      store(2'b00, 16'h0425);
      run_and_check("loads");
   endtask

   task automatic test_alu();
      start_program(16'h0200);
      load_imm(2'b01, 8'h5C);
      alu_imm(3'b000, 8'h21);
      store(2'b01, 16'h0040);
      alu_mem(3'b001, 16'h0080, 8'h3C);
      store(2'b01, 16'h0041);
      alu_imm(3'b010, 8'hFF);
      store(2'b01, 16'h0042);
      set_carry(1'b0);
      alu_imm(3'b011, 8'h70);
      store(2'b01, 16'h0043);
      set_carry(1'b1);
      alu_mem(3'b111, 16'h0600, 8'h95);
      store(2'b01, 16'h0044);
      alu_imm(3'b011, 8'h90);   // Carry in from the SBC
      store(2'b01, 16'h0045);
      run_and_check("alu");
   endtask

   task automatic test_transfers();
      start_program(16'h0200);
      load_imm(2'b10, 8'hFE);
      emit(8'hE8);   // INX
      expect_write(16'h0050, 8'hFF);
      emit(8'h86);
      emit(8'h50);
      emit(8'hE8);
      expect_write(16'h0051, 8'h00);
      emit(8'h86);
      emit(8'h51);
      emit(8'hCA);   // DEX
      expect_write(16'h0052, 8'hFF);
      emit(8'h86);
      emit(8'h52);
      emit(8'h8A);   // TXA
      expect_write(16'h0053, 8'hFF);
      emit(8'h85);
      emit(8'h53);
      emit(8'hA8);   // TAY
      emit(8'hC8);   // INY
      expect_write(16'h0054, 8'h00);
      emit(8'h84);
      emit(8'h54);
      emit(8'h88);   // DEY
      emit(8'h98);   // TYA
      expect_write(16'h0055, 8'hFF);
      emit(8'h85);
      emit(8'h55);
      load_imm(2'b10, 8'h7F);
      emit(8'h9A);   // TXS
      load_imm(2'b10, 8'h00);
      emit(8'hBA);   // TSX
      expect_write(16'h0056, 8'h7F);
      emit(8'h86);
      emit(8'h56);
      load_imm(2'b01, 8'h3A);
      emit(8'hAA);   // TAX
      expect_write(16'h0057, 8'h3A);
      emit(8'h86);
      emit(8'h57);
      run_and_check("transfers");
   endtask

   task automatic build_branches();
      int i;
      load_imm(2'b10, 8'hE7);
      load_imm(2'b01, 8'h00);
      branch_skip(8'hF0, 8'h60);
      branch_skip(8'hD0, 8'h61);
      branch_skip(8'h30, 8'h62);
      branch_skip(8'h10, 8'h63);
      load_imm(2'b01, 8'h80);
      branch_skip(8'h30, 8'h64);
      branch_skip(8'h10, 8'h65);
      load_imm(2'b01, 8'h40);
      alu_imm(3'b110, 8'h40);
      branch_skip(8'hB0, 8'h66);
      branch_skip(8'h90, 8'h67);
      alu_imm(3'b110, 8'h41);
      branch_skip(8'h90, 8'h68);
      branch_skip(8'hB0, 8'h69);
      set_carry(1'b0);
      load_imm(2'b01, 8'h7F);
      alu_imm(3'b011, 8'h01);
      branch_skip(8'h70, 8'h6A);
      branch_skip(8'h50, 8'h6B);
      set_carry(1'b0);
      load_imm(2'b01, 8'h01);
      alu_imm(3'b011, 8'h01);
      branch_skip(8'h50, 8'h6C);
      branch_skip(8'h70, 8'h6D);
      // Backward loop stores 3, 2, 1 then falls through with X at 0
      load_imm(2'b10, 8'h03);
      for (i = 3; i > 0; i--)
         expect_write(16'h0070, i[7:0]);
      emit(8'h86);
      emit(8'h70);
      emit(8'hCA);
      emit(8'hD0);
      emit(8'hFB);
      mx = 8'h00;
      store(2'b10, 16'h0071);
   endtask

   task automatic test_branches();
      start_program(16'h0200);
      build_branches();
      run_and_check("branches");
   endtask

   task automatic test_backpressure();
      int i;
      int n;
      wait_en = 1'b0;
      start_program(16'h0200);
      build_branches();
      run_and_check("no wait");
      n = mem0.wr_count;
      for (i = 0; i < n; i++)
      begin
         ref_addr[i[7:0]] = mem0.wr_addr[i[7:0]];
         ref_data[i[7:0]] = mem0.wr_data[i[7:0]];
      end
      wait_en = 1'b1;
      start_program(16'h0200);
      build_branches();
      run_and_check("wait");
      for (i = 0; i < n; i++)
      begin
         check_addr("stalled write addr", mem0.wr_addr[i[7:0]], ref_addr[i[7:0]]);
         check_data("stalled write data", mem0.wr_data[i[7:0]], ref_data[i[7:0]]);
      end
   endtask

   initial
   begin
      clk          = 1'b0;
      reset_n      = 1'b0;
      wait_en      = 1'b1;
      value_errors = 0;
      other_errors = 0;
      test_reset_vector();
      test_loads_stores();
      test_alu();
      test_transfers();
      test_branches();
      test_backpressure();
      if (mem0.stall_errors != 0 || mem1.stall_errors != 0)
      begin
         $display("A request changed while ready was low");
         other_errors++;
      end
      $display("Errors: %0d value, %0d other", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: m6502_core.f
logic/cpu_bus_pkg.sv
logic/cpu_isa_pkg.sv
logic/m6502_decoder.sv
logic/m6502_sequencer.sv
logic/m6502_registers.sv
logic/m6502_alu.sv
logic/m6502_core.sv
verification/m6502_memory_model.sv
verification/m6502_tb.sv

// File: Makefile
SIM      := verilator
TOP      := m6502_tb
FILELIST := m6502_core.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee $(LOG)
	! grep -q '>>> FAIL' $(LOG)
	grep -q '>>> PASS' $(LOG)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
